// ==== verilog.f ====
+incdir+include
src/rom_chk_pkg.sv
src/rom_chk_rom.sv
src/rom_chk_counter.sv
src/rom_chk_hash.sv
src/rom_chk_compare.sv
src/rom_chk_fsm.sv
src/rom_chk_mux.sv
src/rom_chk_top.sv
tb/rom_chk_tb.sv

// ==== tb/rom_chk_tb.sv ====
// ROM checker testbench with a digest model, LFSR images, bus read checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_tb;

  localparam int LOW_COUNT      = `ROM_DEPTH - `TOP_COUNT;
  localparam int TIMEOUT_CYCLES = 4 * (`ROM_DEPTH + 100);
  localparam rom_chk_pkg::mubi4_t MB_TRUE  = 4'h6;
  localparam rom_chk_pkg::mubi4_t MB_FALSE = 4'h9;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          load_we_i;
  logic [`ROM_AW-1:0]            load_addr_i;
  logic [`WORD_W-1:0]            load_data_i;
  logic                          bus_req_i;
  logic [`ROM_AW-1:0]            bus_addr_i;
  logic                          bus_rvalid_o;
  logic                          bus_err_o;
  logic [`WORD_W-1:0]            bus_rdata_o;
  rom_chk_pkg::mubi4_t           done_o;
  rom_chk_pkg::mubi4_t           good_o;
  logic                          key_valid_o;
  logic [`TOP_COUNT*`WORD_W-1:0] key_digest_o;
  logic                          alert_o;

  // Image as loaded into the ROM, used by the model and the bus checks
  logic [`WORD_W-1:0] img [`ROM_DEPTH];
  logic [31:0]        lfsr_q;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;
  // Request seen at the previous falling edge, answered at the next one
  logic               prev_req;
  logic [`ROM_AW-1:0] prev_addr;
  logic               prev_done;

  rom_chk_top i_rom_chk_top (
    .clk_i, .rst_ni, .load_we_i, .load_addr_i, .load_data_i, .bus_req_i, .bus_addr_i,
    .bus_rvalid_o, .bus_err_o, .bus_rdata_o, .done_o, .good_o, .key_valid_o,
    .key_digest_o, .alert_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog sized for four images, more than the run needs
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the checker did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic report_err(input string msg);
    $display("ERR %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Galois LFSR shifting right, taps of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Word n of the low part folds into slot n mod TOP_COUNT as rotl1(slot) xor word
  function automatic logic [`TOP_COUNT*`WORD_W-1:0] model_digest();
    logic [`TOP_COUNT*`WORD_W-1:0] d;
    logic [`WORD_W-1:0]            cur;
    d = '0;
    for (int n = 0; n < LOW_COUNT; n++) begin
      cur = d[(n % `TOP_COUNT)*`WORD_W +: `WORD_W];
      d[(n % `TOP_COUNT)*`WORD_W +: `WORD_W] = {cur[`WORD_W-2:0], cur[`WORD_W-1]} ^ img[n];
    end
    return d;
  endfunction

  function automatic logic top_matches(input logic [`TOP_COUNT*`WORD_W-1:0] d);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < `TOP_COUNT; k++) begin
      ok = ok & (img[LOW_COUNT+k] == d[k*`WORD_W +: `WORD_W]);
    end
    return ok;
  endfunction

  // Status and bus response checks, sampled on the falling edge where all is stable
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      prev_req  = 1'b0;
      prev_done = 1'b0;
    end else begin
      checks++;
      assert (!alert_o) else report_err("alert_o raised");
      assert (done_o == MB_TRUE || done_o == MB_FALSE)
        else report_err($sformatf("done_o has invalid code %h", done_o));
      assert (key_valid_o == (done_o == MB_TRUE))
        else report_err("key_valid_o does not track done_o");
      if (done_o != MB_TRUE) begin
        assert (good_o == MB_FALSE) else report_err("good_o left false before completion");
      end
      if (prev_done) begin
        assert (done_o == MB_TRUE) else report_err("done_o left true after completion");
      end
      assert (bus_rvalid_o == prev_req)
        else report_err($sformatf("bus_rvalid_o %b, expected %b", bus_rvalid_o, prev_req));
      if (prev_req && prev_done) begin
        assert (!bus_err_o && bus_rdata_o == img[prev_addr])
          else report_err($sformatf("bus read %0d gave err %b data %h, expected %h",
                                    prev_addr, bus_err_o, bus_rdata_o, img[prev_addr]));
      end else if (prev_req) begin
        assert (bus_err_o && bus_rdata_o == '0)
          else report_err($sformatf("early bus read gave err %b data %h",
                                    bus_err_o, bus_rdata_o));
      end
      prev_req  = bus_req_i;
      prev_addr = bus_addr_i;
      prev_done = (done_o == MB_TRUE);
    end
  end

  task automatic bus_read(input logic [`ROM_AW-1:0] addr);
    @(posedge clk_i);
    #1;
    bus_req_i  = 1'b1;
    bus_addr_i = addr;
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    #1;
    bus_req_i = 1'b0;
  endtask

  // Image goes in while reset is low, then reset stays low three more cycles
  task automatic load_and_reset();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    for (int a = 0; a < `ROM_DEPTH; a++) begin
      load_we_i   = 1'b1;
      load_addr_i = a[`ROM_AW-1:0];
      load_data_i = img[a];
      @(posedge clk_i);
      #1;
    end
    load_we_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    checks++;
    assert (done_o == MB_FALSE && good_o == MB_FALSE && !key_valid_o &&
            !bus_rvalid_o && !alert_o)
      else report_err("outputs differ from their reset values");
  endtask

  // Kind 0 is a good image, 1 flips a top bit, 2 flips a low bit after the top is set
  task automatic run_image(input int kind);
    logic [`TOP_COUNT*`WORD_W-1:0] exp_digest;
    logic [31:0]                   r;
    logic                          exp_good;
    int                            n;
    for (int i = 0; i < LOW_COUNT; i++) begin
      img[i] = rand_bits(`WORD_W);
    end
    exp_digest = model_digest();
    for (int k = 0; k < `TOP_COUNT; k++) begin
      img[LOW_COUNT+k] = exp_digest[k*`WORD_W +: `WORD_W];
    end
    if (kind == 1) begin
      r = rand_bits(`TOP_AW + 5);
      img[LOW_COUNT + int'(r[7:5])] = img[LOW_COUNT + int'(r[7:5])] ^ (32'h1 << r[4:0]);
    end else if (kind == 2) begin
      r = rand_bits(`ROM_AW + 5);
      img[int'(r[10:5]) % LOW_COUNT] = img[int'(r[10:5]) % LOW_COUNT] ^ (32'h1 << r[4:0]);
      exp_digest = model_digest();
    end
    exp_good = top_matches(exp_digest);
    load_and_reset();
    // Early read must be refused while the checker owns the ROM
    r = rand_bits(`ROM_AW);
    bus_read(r[`ROM_AW-1:0]);
    bus_idle();
    while (done_o != MB_TRUE) begin
      @(negedge clk_i);
    end
    checks++;
    assert (good_o == (exp_good ? MB_TRUE : MB_FALSE))
      else report_err($sformatf("image %0d good_o %h, expected good %b", kind, good_o, exp_good));
    assert (key_digest_o == exp_digest)
      else report_err($sformatf("key_digest_o %h, expected %h", key_digest_o, exp_digest));
    // Back-to-back reads after the handover
    n = 3 + int'(rand_bits(2));
    for (int j = 0; j < n; j++) begin
      r = rand_bits(`ROM_AW);
      bus_read(r[`ROM_AW-1:0]);
    end
    bus_idle();
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    rst_ni      = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    bus_req_i   = 1'b0;
    bus_addr_i  = '0;
    lfsr_q      = 32'hfbea_d143;
    run_image(0);
    run_image(1);
    run_image(2);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/rom_chk_top.sv ====
// ROM integrity checker top level joining the ROM, counter, hash, compare, FSM and mux
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   load_we_i,
  input  rom_chk_pkg::rom_addr_t load_addr_i,
  input  rom_chk_pkg::rom_word_t load_data_i,
  input  logic                   bus_req_i,
  input  rom_chk_pkg::rom_addr_t bus_addr_i,
  output logic                   bus_rvalid_o,
  output logic                   bus_err_o,
  output rom_chk_pkg::rom_word_t bus_rdata_o,
  output rom_chk_pkg::mubi4_t    done_o,
  output rom_chk_pkg::mubi4_t    good_o,
  output logic                   key_valid_o,
  output rom_chk_pkg::digest_t   key_digest_o,
  output logic                   alert_o
);

  localparam rom_chk_pkg::rom_addr_t TOP_START =
    rom_chk_pkg::rom_addr_t'(`ROM_DEPTH - `TOP_COUNT);

  logic                     rom_req;
  rom_chk_pkg::rom_addr_t   rom_addr;
  rom_chk_pkg::rom_word_t   rom_rdata;
  logic                     cnt_req;
  rom_chk_pkg::rom_addr_t   cnt_addr;
  rom_chk_pkg::rom_addr_t   data_addr;
  rom_chk_pkg::rom_addr_t   rel_addr;
  logic                     cnt_lnt;
  logic                     cnt_done;
  logic                     data_rdy;
  logic                     hash_vld;
  logic                     hash_rdy;
  logic                     hash_done;
  rom_chk_pkg::digest_t     digest;
  logic                     exp_vld;
  logic                     cmp_start;
  logic                     cmp_done;
  logic                     cmp_alert;
  rom_chk_pkg::mubi4_t      cmp_good;

  // Position of the current word inside the top region
  assign rel_addr = data_addr - TOP_START;

  rom_chk_rom i_rom (
    .clk_i, .load_we_i, .load_addr_i, .load_data_i,
    .req_i (rom_req), .addr_i (rom_addr), .rdata_o (rom_rdata)
  );

  rom_chk_counter i_counter (
    .clk_i, .rst_ni, .data_rdy_i (data_rdy), .read_req_o (cnt_req),
    .read_addr_o (cnt_addr), .data_addr_o (data_addr),
    .data_last_nontop_o (cnt_lnt), .done_o (cnt_done)
  );

  rom_chk_hash i_hash (
    .clk_i, .rst_ni, .vld_i (hash_vld), .data_i (rom_rdata), .last_i (cnt_lnt),
    .rdy_o (hash_rdy), .done_o (hash_done), .digest_o (digest)
  );

  rom_chk_compare i_compare (
    .clk_i, .rst_ni, .exp_vld_i (exp_vld), .exp_idx_i (rel_addr[`TOP_AW-1:0]),
    .exp_data_i (rom_rdata), .digest_i (digest), .start_i (cmp_start),
    .done_o (cmp_done), .good_o (cmp_good), .alert_o (cmp_alert)
  );

  rom_chk_fsm i_fsm (
    .clk_i, .rst_ni, .counter_done_i (cnt_done), .counter_lnt_i (cnt_lnt),
    .counter_read_req_i (cnt_req), .data_rdy_o (data_rdy), .hash_rdy_i (hash_rdy),
    .hash_done_i (hash_done), .hash_vld_o (hash_vld), .compare_done_i (cmp_done),
    .compare_good_i (cmp_good), .compare_alert_i (cmp_alert),
    .compare_start_o (cmp_start), .exp_vld_o (exp_vld), .done_o, .good_o,
    .key_valid_o, .alert_o
  );

  rom_chk_mux i_mux (
    .clk_i, .rst_ni, .sel_done_i (done_o), .chk_req_i (cnt_req), .chk_addr_i (cnt_addr),
    .bus_req_i, .bus_addr_i, .rom_req_o (rom_req), .rom_addr_o (rom_addr),
    .rom_rdata_i (rom_rdata), .bus_rvalid_o, .bus_err_o, .bus_rdata_o
  );

  // The computed digest goes to the key manager as is
  assign key_digest_o = digest;

endmodule

`default_nettype wire

// ==== src/rom_chk_mux.sv ====
// ROM access mux handing the ROM from the checker to the bus once the check is done
`timescale 1ns/1ps
`default_nettype none

module rom_chk_mux (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rom_chk_pkg::mubi4_t    sel_done_i,
  input  logic                   chk_req_i,
  input  rom_chk_pkg::rom_addr_t chk_addr_i,
  input  logic                   bus_req_i,
  input  rom_chk_pkg::rom_addr_t bus_addr_i,
  output logic                   rom_req_o,
  output rom_chk_pkg::rom_addr_t rom_addr_o,
  input  rom_chk_pkg::rom_word_t rom_rdata_i,
  output logic                   bus_rvalid_o,
  output logic                   bus_err_o,
  output rom_chk_pkg::rom_word_t bus_rdata_o
);

  logic sel_bus;
  logic rvalid_q;
  logic err_q;

  // Only an exact true value hands the ROM over
  assign sel_bus    = (sel_done_i == rom_chk_pkg::MUBI4_TRUE);
  assign rom_req_o  = sel_bus ? bus_req_i : chk_req_i;
  assign rom_addr_o = sel_bus ? bus_addr_i : chk_addr_i;

  // Bus requests made before the handover are answered with an error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i;
      err_q    <= bus_req_i & ~sel_bus;
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_err_o    = err_q;
  // Checker data on the ROM output is never exposed to the bus
  assign bus_rdata_o  = (rvalid_q && !err_q) ? rom_rdata_i : '0;

endmodule

`default_nettype wire

// ==== src/rom_chk_fsm.sv ====
// Main checker FSM driving the hash stream, the compare start and the status outputs
`timescale 1ns/1ps
`default_nettype none

module rom_chk_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                counter_done_i,
  input  logic                counter_lnt_i,
  input  logic                counter_read_req_i,
  output logic                data_rdy_o,
  input  logic                hash_rdy_i,
  input  logic                hash_done_i,
  output logic                hash_vld_o,
  input  logic                compare_done_i,
  input  rom_chk_pkg::mubi4_t compare_good_i,
  input  logic                compare_alert_i,
  output logic                compare_start_o,
  output logic                exp_vld_o,
  output rom_chk_pkg::mubi4_t done_o,
  output rom_chk_pkg::mubi4_t good_o,
  output logic                key_valid_o,
  output logic                alert_o
);

  rom_chk_pkg::fsm_state_e state_d;
  rom_chk_pkg::fsm_state_e state_q;
  rom_chk_pkg::mubi4_t     in_state_done;
  logic                    fsm_alert;
  logic                    hash_vld_d;
  logic                    hash_vld_q;
  logic                    start_q;
  logic                    high_phase;
  logic                    unexpected_counter_change;

  // Linear path with one race branch while the top words are read
  // RomAhead means the reads finished first, HashAhead means the hash did
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      rom_chk_pkg::ReadingLow: begin
        if (counter_lnt_i && hash_vld_o && hash_rdy_i) begin
          state_d = rom_chk_pkg::ReadingHigh;
        end
      end
      rom_chk_pkg::ReadingHigh: begin
        unique case ({hash_done_i, counter_done_i})
          2'b01:   state_d = rom_chk_pkg::RomAhead;
          2'b10:   state_d = rom_chk_pkg::HashAhead;
          2'b11:   state_d = rom_chk_pkg::Checking;
          default: state_d = rom_chk_pkg::ReadingHigh;
        endcase
      end
      rom_chk_pkg::RomAhead: begin
        if (hash_done_i) begin
          state_d = rom_chk_pkg::Checking;
        end
      end
      rom_chk_pkg::HashAhead: begin
        if (counter_done_i) begin
          state_d = rom_chk_pkg::Checking;
        end
      end
      rom_chk_pkg::Checking: begin
        if (compare_done_i) begin
          state_d = rom_chk_pkg::Done;
        end
      end
      rom_chk_pkg::Done: begin
        state_d = rom_chk_pkg::Done;
      end
      default: begin
        // Invalid and any corrupted code end up here and stay
        fsm_alert = 1'b1;
        state_d   = rom_chk_pkg::Invalid;
      end
    endcase

    // Done strobes that arrive in the wrong phase mean the sequence was broken
    if ((compare_done_i &&
         !(state_q inside {rom_chk_pkg::Checking, rom_chk_pkg::Done})) ||
        (counter_done_i && (state_q == rom_chk_pkg::ReadingLow)) ||
        (hash_done_i &&
         !(state_q inside {rom_chk_pkg::ReadingHigh, rom_chk_pkg::RomAhead}))) begin
      state_d = rom_chk_pkg::Invalid;
    end
    if (alert_o) begin
      state_d = rom_chk_pkg::Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rom_chk_pkg::ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // A cast to the 4-bit type keeps the low nibble, which is MUBI4_TRUE only in Done
  assign in_state_done = rom_chk_pkg::mubi4_t'(state_q);

  // Words read in ReadingLow become hash input, except the read that follows the last low word
  always_comb begin
    hash_vld_d = hash_vld_q;
    if (hash_rdy_i) begin
      hash_vld_d = 1'b0;
    end
    if (counter_read_req_i && (state_q == rom_chk_pkg::ReadingLow) && !counter_lnt_i) begin
      hash_vld_d = 1'b1;
    end
  end

  // Start pulse follows the entry into Checking
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hash_vld_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      hash_vld_q <= hash_vld_d;
      start_q    <= (state_q != rom_chk_pkg::Checking) && (state_d == rom_chk_pkg::Checking);
    end
  end

  // During the top reads nobody applies back-pressure, each word is snooped as it passes
  assign high_phase = state_q inside {rom_chk_pkg::ReadingHigh, rom_chk_pkg::HashAhead};
  assign data_rdy_o = hash_rdy_i | high_phase;
  assign exp_vld_o  = high_phase & ~counter_done_i;

  assign hash_vld_o      = hash_vld_q;
  assign compare_start_o = start_q;

  assign done_o      = in_state_done;
  assign key_valid_o = (in_state_done == rom_chk_pkg::MUBI4_TRUE);
  // The verdict only reaches the power manager once the FSM sits in Done
  assign good_o      = key_valid_o ? compare_good_i : rom_chk_pkg::MUBI4_FALSE;

  // The counter done is sticky, so losing it in Done points to a tampered address counter
  assign unexpected_counter_change = key_valid_o & ~counter_done_i;
  assign alert_o = fsm_alert | compare_alert_i | unexpected_counter_change;

endmodule

`default_nettype wire

// ==== src/rom_chk_compare.sv ====
// Expected digest store and word-by-word comparison against the computed digest
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_compare (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     exp_vld_i,
  input  rom_chk_pkg::digest_idx_t exp_idx_i,
  input  rom_chk_pkg::rom_word_t   exp_data_i,
  input  rom_chk_pkg::digest_t     digest_i,
  input  logic                     start_i,
  output logic                     done_o,
  output rom_chk_pkg::mubi4_t      good_o,
  output logic                     alert_o
);

  rom_chk_pkg::rom_word_t   exp_q [`TOP_COUNT];
  rom_chk_pkg::digest_idx_t idx_q;
  logic                     busy_q;
  logic                     mismatch_q;
  logic                     done_q;
  logic                     alert_q;
  rom_chk_pkg::mubi4_t      good_q;
  logic                     word_bad;
  logic                     last_idx;

  // Top ROM words are snooped into the bank as the counter passes them
  always_ff @(posedge clk_i) begin
    if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_data_i;
    end
  end

  assign word_bad = digest_i[idx_q*`WORD_W +: `WORD_W] != exp_q[idx_q];
  assign last_idx = (idx_q == rom_chk_pkg::digest_idx_t'(`TOP_COUNT - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q      <= '0;
      busy_q     <= 1'b0;
      mismatch_q <= 1'b0;
      done_q     <= 1'b0;
      alert_q    <= 1'b0;
      good_q     <= rom_chk_pkg::MUBI4_FALSE;
    end else begin
      done_q <= 1'b0;
      if (busy_q) begin
        idx_q      <= idx_q + 1'b1;
        mismatch_q <= mismatch_q | word_bad;
        // The final word decides the verdict, which then stays latched
        if (last_idx) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          good_q <= (mismatch_q | word_bad) ? rom_chk_pkg::MUBI4_FALSE
                                            : rom_chk_pkg::MUBI4_TRUE;
        end
      end else if (start_i) begin
        busy_q     <= 1'b1;
        idx_q      <= '0;
        mismatch_q <= 1'b0;
      end
      // Restarting mid-walk means the control flow was disturbed
      if (start_i && busy_q) begin
        alert_q <= 1'b1;
      end
    end
  end

  assign done_o  = done_q;
  assign good_o  = good_q;
  assign alert_o = alert_q;

endmodule

`default_nettype wire

// ==== src/rom_chk_hash.sv ====
// Rotate-xor block hash standing in for KMAC, with valid/ready input and a done pulse
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_hash (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   vld_i,
  input  rom_chk_pkg::rom_word_t data_i,
  input  logic                   last_i,
  output logic                   rdy_o,
  output logic                   done_o,
  output rom_chk_pkg::digest_t   digest_o
);

  rom_chk_pkg::digest_t    digest_q;
  rom_chk_pkg::rom_addr_t  cnt_q;
  logic                    gap_q;
  logic                    sealed_q;
  logic [1:0]              fin_q;
  logic                    accept;
  logic                    blk_end;
  rom_chk_pkg::digest_idx_t idx;
  rom_chk_pkg::rom_word_t  cur_word;
  rom_chk_pkg::rom_word_t  new_word;

  // One idle cycle after each full block, and no more input once the last word is in
  assign rdy_o  = ~gap_q & ~sealed_q;
  assign accept = vld_i & rdy_o;

  // Word n lands in digest slot n mod TOP_COUNT
  assign idx      = cnt_q[`TOP_AW-1:0];
  assign cur_word = digest_q[idx*`WORD_W +: `WORD_W];
  assign new_word = {cur_word[`WORD_W-2:0], cur_word[`WORD_W-1]} ^ data_i;
  assign blk_end  = (cnt_q % `HASH_BLOCK) == (`HASH_BLOCK - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
      cnt_q    <= '0;
      gap_q    <= 1'b0;
      sealed_q <= 1'b0;
      fin_q    <= 2'd0;
    end else begin
      gap_q <= accept & blk_end;
      if (accept) begin
        cnt_q                             <= cnt_q + 1'b1;
        digest_q[idx*`WORD_W +: `WORD_W] <= new_word;
      end
      // Finalize countdown runs 3, 2, 1 and done fires on the last step
      if (accept && last_i) begin
        sealed_q <= 1'b1;
        fin_q    <= 2'd3;
      end else if (fin_q != 2'd0) begin
        fin_q <= fin_q - 2'd1;
      end
    end
  end

  assign done_o   = (fin_q == 2'd1);
  assign digest_o = digest_q;

endmodule

`default_nettype wire

// ==== src/rom_chk_counter.sv ====
// Address generator that walks the ROM from zero to the top, one pending word at a time
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_rdy_i,
  output logic                   read_req_o,
  output rom_chk_pkg::rom_addr_t read_addr_o,
  output rom_chk_pkg::rom_addr_t data_addr_o,
  output logic                   data_last_nontop_o,
  output logic                   done_o
);

  localparam rom_chk_pkg::rom_addr_t LAST_ADDR =
    rom_chk_pkg::rom_addr_t'(`ROM_DEPTH - 1);
  localparam rom_chk_pkg::rom_addr_t LAST_LOW_ADDR =
    rom_chk_pkg::rom_addr_t'(`ROM_DEPTH - `TOP_COUNT - 1);

  rom_chk_pkg::rom_addr_t addr_q;
  rom_chk_pkg::rom_addr_t data_addr_q;
  logic                   vld_q;
  logic                   reads_done_q;
  logic                   done_q;

  // A new read goes out when nothing is pending or the pending word is being consumed
  assign read_req_o = ~reads_done_q & (~vld_q | data_rdy_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      data_addr_q  <= '0;
      vld_q        <= 1'b0;
      reads_done_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      if (read_req_o) begin
        addr_q       <= addr_q + 1'b1;
        data_addr_q  <= addr_q;
        reads_done_q <= (addr_q == LAST_ADDR);
      end
      // The word on the ROM output stays pending until it is consumed
      if (read_req_o) begin
        vld_q <= 1'b1;
      end else if (data_rdy_i) begin
        vld_q <= 1'b0;
      end
      // Sticky once the top word has been consumed
      if (vld_q && data_rdy_i && (data_addr_q == LAST_ADDR)) begin
        done_q <= 1'b1;
      end
    end
  end

  assign read_addr_o        = addr_q;
  assign data_addr_o        = data_addr_q;
  assign data_last_nontop_o = vld_q & (data_addr_q == LAST_LOW_ADDR);
  assign done_o             = done_q;

endmodule

`default_nettype wire

// ==== src/rom_chk_rom.sv ====
// ROM array with a one-cycle registered read and a load port for use under reset
`timescale 1ns/1ps
`default_nettype none

`include "rom_chk_defs.svh"

module rom_chk_rom (
  input  logic                  clk_i,
  input  logic                  load_we_i,
  input  rom_chk_pkg::rom_addr_t load_addr_i,
  input  rom_chk_pkg::rom_word_t load_data_i,
  input  logic                  req_i,
  input  rom_chk_pkg::rom_addr_t addr_i,
  output rom_chk_pkg::rom_word_t rdata_o
);

  rom_chk_pkg::rom_word_t mem_q [`ROM_DEPTH];
  rom_chk_pkg::rom_word_t rdata_q;

  // The image is written while the rest of the system sits in reset
  // Read data stays put until the next request, so a pending word is stable
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
    if (req_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== src/rom_chk_pkg.sv ====
// ROM checker package with data widths, multi-bit booleans and the FSM encoding
`default_nettype none

`include "rom_chk_defs.svh"

package rom_chk_pkg;

  typedef logic [`ROM_AW-1:0] rom_addr_t;
  typedef logic [`WORD_W-1:0] rom_word_t;
  typedef logic [`TOP_AW-1:0] digest_idx_t;

  // Word 0 of the digest sits in the least significant bits
  typedef logic [`TOP_COUNT*`WORD_W-1:0] digest_t;

  // Multi-bit boolean so that a single flipped bit cannot read as true
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t MUBI4_TRUE  = 4'h6;
  localparam mubi4_t MUBI4_FALSE = 4'h9;

  // Sparse state code, the upper six bits keep the states apart
  // Only Done carries MUBI4_TRUE in its low nibble, every other state carries MUBI4_FALSE
  typedef enum logic [9:0] {
    ReadingLow  = 10'b101100_1001,
    ReadingHigh = 10'b010110_1001,
    RomAhead    = 10'b111010_1001,
    HashAhead   = 10'b001011_1001,
    Checking    = 10'b100111_1001,
    Done        = 10'b011101_0110,
    Invalid     = 10'b110001_1001
  } fsm_state_e;

endpackage

`default_nettype wire

// ==== include/rom_chk_defs.svh ====
// ROM checker size definitions shared by the package and the RTL
`ifndef ROM_CHK_DEFS_SVH
`define ROM_CHK_DEFS_SVH

// Number of words in the ROM and the width of a word address
`define ROM_DEPTH 64
`define ROM_AW 6

// Expected digest words stored at the top of the ROM and their index width
`define TOP_COUNT 8
`define TOP_AW 3

// Width of one ROM data word
`define WORD_W 32

// Words the hash absorbs before it inserts an idle cycle
`define HASH_BLOCK 4

`endif
